//--- Makefile
TOP := tb_sram_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the trace and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sram_subsystem.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- source/axil_pkg.sv
`default_nettype none

// AXI4-Lite channel payloads
// valid and ready travel beside these as plain ports
package axil_pkg;

  parameter int AXIL_ADDR_BITS = 32;
  parameter int AXIL_DATA_BITS = 32;

  // one strobe bit per byte lane
  parameter int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;

  // response codes, this subsystem only ever answers OKAY
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_e;

  // write address channel
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0] addr;
  } axil_aw_t;

  // write data channel
  typedef struct packed {
    logic [AXIL_DATA_BITS-1:0] data;
    logic [AXIL_STRB_BITS-1:0] strb;
  } axil_w_t;

  // write response channel
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  // read address channel
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0] addr;
  } axil_ar_t;

  // read data channel
  typedef struct packed {
    logic [AXIL_DATA_BITS-1:0] data;
    axil_resp_e                resp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- source/axil_sram_port.sv
`timescale 1ns/10ps
`default_nettype none

module axil_sram_port #(
  parameter int ADDR_BITS = sram_pkg::ADDR_BITS,
  parameter int DATA_BITS = sram_pkg::DATA_BITS
) (
  input  logic                clk,
  input  logic                reset,
  // write address channel
  input  logic                awvalid,
  output logic                awready,
  input  axil_pkg::axil_aw_t  aw,
  // write data channel, strobes are not used by the chip
  input  logic                wvalid,
  output logic                wready,
  input  axil_pkg::axil_w_t   w,
  // write response channel
  output logic                bvalid,
  input  logic                bready,
  output axil_pkg::axil_b_t   b,
  // read address channel
  input  logic                arvalid,
  output logic                arready,
  input  axil_pkg::axil_ar_t  ar,
  // read data channel
  output logic                rvalid,
  input  logic                rready,
  output axil_pkg::axil_r_t   r,
  // toward the arbiter
  output sram_pkg::sram_req_t sram_req,
  input  logic                grant,
  input  sram_pkg::sram_rsp_t sram_rsp
);

  import axil_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e                    state;
  // goes high one cycle after reset so the ready outputs open late
  logic                      up;
  logic                      op_read;
  logic                      last_read;
  logic                      aw_held;
  logic                      w_held;
  logic                      ar_held;
  logic [AXIL_ADDR_BITS-1:0] aw_addr_q;
  logic [AXIL_ADDR_BITS-1:0] ar_addr_q;
  logic [AXIL_DATA_BITS-1:0] w_data_q;
  logic [ADDR_BITS-1:0]      req_addr_q;
  logic [DATA_BITS-1:0]      req_wdata_q;
  logic [DATA_BITS-1:0]      rdata_q;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      ar_fire;
  logic                      b_fire;
  logic                      r_fire;
  logic                      rd_busy;
  logic                      wr_busy;
  logic                      rd_now;
  logic                      wr_now;
  logic                      issue_rd;
  logic                      issue_wr;
  logic [AXIL_ADDR_BITS-1:0] rd_addr;
  logic [AXIL_ADDR_BITS-1:0] wr_addr;
  logic [AXIL_DATA_BITS-1:0] wr_data;

  // a channel stays closed while its own access is in flight or unanswered
  assign rd_busy = (state != ST_IDLE) && op_read;
  assign wr_busy = (state != ST_IDLE) && !op_read;

  assign awready = up && !aw_held && !wr_busy;
  assign wready  = up && !w_held && !wr_busy;
  assign arready = up && !ar_held && !rd_busy;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign ar_fire = arvalid && arready;
  assign b_fire  = bvalid && bready;
  assign r_fire  = rvalid && rready;

  // work available now, either held or arriving this edge
  assign rd_now  = ar_held || ar_fire;
  assign wr_now  = (aw_held || aw_fire) && (w_held || w_fire);
  assign rd_addr = ar_held ? ar_addr_q : ar.addr;
  assign wr_addr = aw_held ? aw_addr_q : aw.addr;
  assign wr_data = w_held ? w_data_q : w.data;

  // when both kinds wait, take the one not served last
  assign issue_rd = (state == ST_IDLE) && rd_now && (!wr_now || !last_read);
  assign issue_wr = (state == ST_IDLE) && wr_now && !issue_rd;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      up        <= 1'b0;
      state     <= ST_IDLE;
      op_read   <= 1'b0;
      last_read <= 1'b0;
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      ar_held   <= 1'b0;
    end else begin
      up <= 1'b1;
      if (aw_fire) begin
        aw_held <= 1'b1;
      end
      if (w_fire) begin
        w_held <= 1'b1;
      end
      if (ar_fire) begin
        ar_held <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          // issuing consumes the held channels, overriding a same-edge capture
          if (issue_rd) begin
            ar_held   <= 1'b0;
            op_read   <= 1'b1;
            last_read <= 1'b1;
            state     <= ST_REQ;
          end else if (issue_wr) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            op_read   <= 1'b0;
            last_read <= 1'b0;
            state     <= ST_REQ;
          end
        end
        ST_REQ: begin
          // grant already implies the controller took it
          if (grant) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (sram_rsp.done) begin
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (b_fire || r_fire) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // channel payloads and the outgoing request
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_addr_q <= aw.addr;
    end
    if (w_fire) begin
      w_data_q <= w.data;
    end
    if (ar_fire) begin
      ar_addr_q <= ar.addr;
    end
    // byte address to halfword address, bit 0 dropped
    if (issue_rd) begin
      req_addr_q <= rd_addr[ADDR_BITS:1];
    end else if (issue_wr) begin
      req_addr_q  <= wr_addr[ADDR_BITS:1];
      req_wdata_q <= wr_data[DATA_BITS-1:0];
    end
    if ((state == ST_WAIT) && sram_rsp.done && op_read) begin
      rdata_q <= sram_rsp.rdata;
    end
  end

  assign sram_req = '{
    valid: (state == ST_REQ),
    write: !op_read,
    addr:  req_addr_q,
    wdata: req_wdata_q
  };

  // responses hold until the master takes them
  assign bvalid = (state == ST_RESP) && !op_read;
  assign rvalid = (state == ST_RESP) && op_read;
  assign b      = '{resp: AXIL_OKAY};
  // halfword zero-extended onto the 32-bit bus
  assign r      = '{data: {{(AXIL_DATA_BITS-DATA_BITS){1'b0}}, rdata_q}, resp: AXIL_OKAY};

endmodule

`default_nettype wire

//--- source/sram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sram_arbiter #(
  parameter int ADDR_BITS = sram_pkg::ADDR_BITS,
  parameter int DATA_BITS = sram_pkg::DATA_BITS
) (
  input  logic                                          clk,
  input  logic                                          reset,
  // one request and one completion per port
  input  sram_pkg::sram_req_t [sram_pkg::NUM_PORTS-1:0] port_req,
  output logic                [sram_pkg::NUM_PORTS-1:0] port_grant,
  output sram_pkg::sram_rsp_t [sram_pkg::NUM_PORTS-1:0] port_rsp,
  // single controller
  output sram_pkg::sram_req_t                           ctrl_req,
  output logic                                          ctrl_accept,
  input  logic                                          ctrl_ready,
  input  sram_pkg::sram_rsp_t                           ctrl_rsp
);

  import sram_pkg::*;

  // port that wins a tie next time
  logic                 prio;
  // port that owns the access now in the controller
  logic                 owner;
  // index of the granted port
  logic                 sel;
  logic                 sel_write;
  logic [ADDR_BITS-1:0] sel_addr;
  logic [DATA_BITS-1:0] sel_wdata;

  // grant only while the controller can take an access
  always_comb begin
    port_grant = '0;
    sel        = prio;
    if (ctrl_ready) begin
      if (port_req[prio].valid) begin
        port_grant[prio] = 1'b1;
      end else if (port_req[!prio].valid) begin
        port_grant[!prio] = 1'b1;
        sel               = !prio;
      end
    end
  end

  assign ctrl_accept = |port_grant;

  // forward the winner's fields
  assign sel_write = port_req[sel].write;
  assign sel_addr  = port_req[sel].addr;
  assign sel_wdata = port_req[sel].wdata;

  assign ctrl_req = '{
    valid: ctrl_accept,
    write: sel_write,
    addr:  sel_addr,
    wdata: sel_wdata
  };

  // rotate after every grant and remember who owns the access
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prio  <= 1'b0;
      owner <= 1'b0;
    end else if (ctrl_accept) begin
      prio  <= !sel;
      owner <= sel;
    end
  end

  // completion goes only to the owner, the other port sees nothing
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (owner == i[0]) begin
        port_rsp[i] = ctrl_rsp;
      end else begin
        port_rsp[i] = '{done: 1'b0, rdata: {DATA_BITS{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sram_controller.sv
`timescale 1ns/10ps
`default_nettype none

module sram_controller #(
  parameter int ADDR_BITS = sram_pkg::ADDR_BITS,
  parameter int DATA_BITS = sram_pkg::DATA_BITS
) (
  input  logic                 clk,
  input  logic                 reset,
  // access from the arbiter
  input  sram_pkg::sram_req_t  req,
  input  logic                 accept,
  output logic                 ready,
  output sram_pkg::sram_rsp_t  rsp,
  // chip pins
  output logic [ADDR_BITS-1:0] sram_addr,
  inout  wire  [DATA_BITS-1:0] sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  // access sequence, two cycles per access
  //   rise 0  accept, latch addr and data, start driving bus on a write
  //   fall 0  strobe low
  //   rise 1  second phase, nothing moves
  //   fall 1  strobe high, read data sampled
  //   rise 2  done, bus released
  // strobes sit half a cycle inside the address/data window on both sides

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READING,
    ST_WRITING
  } state_e;

  state_e               state;
  // low in the first cycle of an access, high in the second
  logic                 phase;
  logic                 start;
  logic                 done_q;
  logic                 next_we_n;
  logic                 next_oe_n;
  logic [ADDR_BITS-1:0] addr_q;
  logic [DATA_BITS-1:0] wdata_q;
  logic [DATA_BITS-1:0] rdata_q;

  assign ready = (state == ST_IDLE);
  assign start = accept && req.valid && ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state  <= ST_IDLE;
      phase  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // done lands right after the second phase
      done_q <= (state != ST_IDLE) && phase;
      case (state)
        ST_IDLE: begin
          phase <= 1'b0;
          if (start) begin
            state <= req.write ? ST_WRITING : ST_READING;
          end
        end
        ST_READING, ST_WRITING: begin
          if (!phase) begin
            phase <= 1'b1;
          end else begin
            phase <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // address and write data stay put for the whole access
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
  end

  // strobe only in the first phase, picked up at the next falling edge
  assign next_oe_n = !((state == ST_READING) && !phase);
  assign next_we_n = !((state == ST_WRITING) && !phase);

  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
    end else begin
      sram_oe_n <= next_oe_n;
      sram_we_n <= next_we_n;
    end
  end

  // sampled at the edge that releases oe_n, a full cycle after it fell
  always_ff @(negedge clk) begin
    if (!sram_oe_n) begin
      rdata_q <= sram_data;
    end
  end

  // chip stays selected, the strobes do the work
  assign sram_ce_n = 1'b0;
  assign sram_addr = addr_q;

  // bus driven for both write cycles, high impedance otherwise
  assign sram_data = (state == ST_WRITING) ? wdata_q : {DATA_BITS{1'bz}};

  assign rsp = '{done: done_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- source/sram_pkg.sv
`default_nettype none

// chip geometry and the request/completion records shared by ports, arbiter and controller
package sram_pkg;

  // halfword address width of the external chip
  parameter int ADDR_BITS = 20;

  // data bus width, no byte lanes on this part
  parameter int DATA_BITS = 16;

  // requesters that share the single controller
  parameter int NUM_PORTS = 2;

  // one access from a port
  // held stable by the port until granted
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } sram_req_t;

  // completion of an access
  // done pulses for one cycle, rdata only meaningful after a read
  typedef struct packed {
    logic                 done;
    logic [DATA_BITS-1:0] rdata;
  } sram_rsp_t;

endpackage

`default_nettype wire

//--- source/sram_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module sram_subsystem #(
  parameter int ADDR_BITS = sram_pkg::ADDR_BITS,
  parameter int DATA_BITS = sram_pkg::DATA_BITS
) (
  input  logic                 clk,
  input  logic                 reset,
  // master 0, processor data port
  input  logic                 s0_awvalid,
  output logic                 s0_awready,
  input  axil_pkg::axil_aw_t   s0_aw,
  input  logic                 s0_wvalid,
  output logic                 s0_wready,
  input  axil_pkg::axil_w_t    s0_w,
  output logic                 s0_bvalid,
  input  logic                 s0_bready,
  output axil_pkg::axil_b_t    s0_b,
  input  logic                 s0_arvalid,
  output logic                 s0_arready,
  input  axil_pkg::axil_ar_t   s0_ar,
  output logic                 s0_rvalid,
  input  logic                 s0_rready,
  output axil_pkg::axil_r_t    s0_r,
  // master 1, dma or display fetch
  input  logic                 s1_awvalid,
  output logic                 s1_awready,
  input  axil_pkg::axil_aw_t   s1_aw,
  input  logic                 s1_wvalid,
  output logic                 s1_wready,
  input  axil_pkg::axil_w_t    s1_w,
  output logic                 s1_bvalid,
  input  logic                 s1_bready,
  output axil_pkg::axil_b_t    s1_b,
  input  logic                 s1_arvalid,
  output logic                 s1_arready,
  input  axil_pkg::axil_ar_t   s1_ar,
  output logic                 s1_rvalid,
  input  logic                 s1_rready,
  output axil_pkg::axil_r_t    s1_r,
  // chip pins
  output logic [ADDR_BITS-1:0] sram_addr,
  inout  wire  [DATA_BITS-1:0] sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  import sram_pkg::*;

  sram_req_t [NUM_PORTS-1:0] port_req;
  logic      [NUM_PORTS-1:0] port_grant;
  sram_rsp_t [NUM_PORTS-1:0] port_rsp;
  sram_req_t                 ctrl_req;
  logic                      ctrl_accept;
  logic                      ctrl_ready;
  sram_rsp_t                 ctrl_rsp;

  // front end for master 0
  axil_sram_port #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS)
  ) u_port0 (
    .clk      (clk),
    .reset    (reset),
    .awvalid  (s0_awvalid),
    .awready  (s0_awready),
    .aw       (s0_aw),
    .wvalid   (s0_wvalid),
    .wready   (s0_wready),
    .w        (s0_w),
    .bvalid   (s0_bvalid),
    .bready   (s0_bready),
    .b        (s0_b),
    .arvalid  (s0_arvalid),
    .arready  (s0_arready),
    .ar       (s0_ar),
    .rvalid   (s0_rvalid),
    .rready   (s0_rready),
    .r        (s0_r),
    .sram_req (port_req[0]),
    .grant    (port_grant[0]),
    .sram_rsp (port_rsp[0])
  );

  // front end for master 1
  axil_sram_port #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS)
  ) u_port1 (
    .clk      (clk),
    .reset    (reset),
    .awvalid  (s1_awvalid),
    .awready  (s1_awready),
    .aw       (s1_aw),
    .wvalid   (s1_wvalid),
    .wready   (s1_wready),
    .w        (s1_w),
    .bvalid   (s1_bvalid),
    .bready   (s1_bready),
    .b        (s1_b),
    .arvalid  (s1_arvalid),
    .arready  (s1_arready),
    .ar       (s1_ar),
    .rvalid   (s1_rvalid),
    .rready   (s1_rready),
    .r        (s1_r),
    .sram_req (port_req[1]),
    .grant    (port_grant[1]),
    .sram_rsp (port_rsp[1])
  );

  // round-robin share of the controller
  sram_arbiter #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS)
  ) u_arbiter (
    .clk         (clk),
    .reset       (reset),
    .port_req    (port_req),
    .port_grant  (port_grant),
    .port_rsp    (port_rsp),
    .ctrl_req    (ctrl_req),
    .ctrl_accept (ctrl_accept),
    .ctrl_ready  (ctrl_ready),
    .ctrl_rsp    (ctrl_rsp)
  );

  // pin sequencer
  sram_controller #(
    .ADDR_BITS (ADDR_BITS),
    .DATA_BITS (DATA_BITS)
  ) u_controller (
    .clk       (clk),
    .reset     (reset),
    .req       (ctrl_req),
    .accept    (ctrl_accept),
    .ready     (ctrl_ready),
    .rsp       (ctrl_rsp),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

endmodule

`default_nettype wire

//--- sram_subsystem.f
source/sram_pkg.sv
source/axil_pkg.sv
source/axil_sram_port.sv
source/sram_arbiter.sv
source/sram_controller.sv
source/sram_subsystem.sv
tb/sram_model.sv
tb/tb_sram_subsystem.sv

//--- tb/sram_model.sv
`timescale 1ns/10ps
`default_nettype none

// asynchronous sram chip, 16-bit wide, no byte lanes
module sram_model #(
  parameter int ADDR_BITS = 20,
  parameter int DATA_BITS = 16
) (
  input  wire [ADDR_BITS-1:0] addr,
  inout  wire [DATA_BITS-1:0] data,
  input  wire                 we_n,
  input  wire                 oe_n,
  input  wire                 ce_n
);

  logic [DATA_BITS-1:0] mem [0:(1 << ADDR_BITS) - 1];

  // chip drives the bus only for a selected read with write disabled
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : {DATA_BITS{1'bz}};

  // data is latched at the rising edge of we_n, end of the write pulse
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] <= data;
    end
  end

endmodule

`default_nettype wire

//--- tb/sram_trace.txt
// port_op_hwaddr_wdata_expected_stall, op 1 write 0 read
// port 0 uses hwaddr 0x10.., port 1 uses 0x8000.., reads expect low 16 bits zero-extended
0_1_00000010_1234abcd_00000000_00
1_1_00008000_0000c3c3_00000000_02
0_0_00000010_00000000_0000abcd_02
1_1_00008001_87654321_00000000_00
0_1_00000011_ffff5a5a_00000000_01
1_0_00008000_00000000_0000c3c3_04
0_1_00000012_00000001_00000000_00
1_0_00008001_00000000_00004321_00
0_0_00000011_00000000_00005a5a_00
1_1_00008002_a5a5ffff_00000000_03
0_0_00000012_00000000_00000001_03
1_0_00008002_00000000_0000ffff_01
0_1_00000010_dead0000_00000000_00
1_1_00008000_00010002_00000000_00
0_0_00000010_00000000_00000000_01
1_0_00008000_00000000_00000002_05
0_1_00000013_00007e81_00000000_02
1_1_00008003_fedcba98_00000000_01
0_0_00000013_00000000_00007e81_00
1_0_00008003_00000000_0000ba98_02
0_0_00000011_00000000_00005a5a_04
1_0_00008001_00000000_00004321_00
0_1_00000011_0f0f0f0f_00000000_00
1_0_00008002_00000000_0000ffff_03
0_0_00000011_00000000_00000f0f_00
1_1_00008002_00000000_00000000_00
0_0_00000012_00000000_00000001_01
1_0_00008002_00000000_00000000_02

//--- tb/tb_sram_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sram_subsystem;

  import axil_pkg::*;

  localparam int MAX_OPS = 64;
  localparam int RESET_CYCLES = 16;

  logic clk;
  logic reset;
  logic awvalid [2];
  logic awready [2];
  axil_aw_t aw [2];
  logic wvalid [2];
  logic wready [2];
  axil_w_t w [2];
  logic bvalid [2];
  logic bready [2];
  axil_b_t b [2];
  logic arvalid [2];
  logic arready [2];
  axil_ar_t ar [2];
  logic rvalid [2];
  logic rready [2];
  axil_r_t r [2];
  logic [sram_pkg::ADDR_BITS-1:0] sram_addr;
  wire  [sram_pkg::DATA_BITS-1:0] sram_data;
  logic sram_we_n;
  logic sram_oe_n;
  logic sram_ce_n;

  // one trace line holds port, op, hwaddr, wdata, expected and stall
  logic [111:0] trace [0:MAX_OPS-1];
  int num_ops;
  int errors;
  logic loaded;

  sram_subsystem #(
    .ADDR_BITS (sram_pkg::ADDR_BITS),
    .DATA_BITS (sram_pkg::DATA_BITS)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .s0_awvalid (awvalid[0]),
    .s0_awready (awready[0]),
    .s0_aw      (aw[0]),
    .s0_wvalid  (wvalid[0]),
    .s0_wready  (wready[0]),
    .s0_w       (w[0]),
    .s0_bvalid  (bvalid[0]),
    .s0_bready  (bready[0]),
    .s0_b       (b[0]),
    .s0_arvalid (arvalid[0]),
    .s0_arready (arready[0]),
    .s0_ar      (ar[0]),
    .s0_rvalid  (rvalid[0]),
    .s0_rready  (rready[0]),
    .s0_r       (r[0]),
    .s1_awvalid (awvalid[1]),
    .s1_awready (awready[1]),
    .s1_aw      (aw[1]),
    .s1_wvalid  (wvalid[1]),
    .s1_wready  (wready[1]),
    .s1_w       (w[1]),
    .s1_bvalid  (bvalid[1]),
    .s1_bready  (bready[1]),
    .s1_b       (b[1]),
    .s1_arvalid (arvalid[1]),
    .s1_arready (arready[1]),
    .s1_ar      (ar[1]),
    .s1_rvalid  (rvalid[1]),
    .s1_rready  (rready[1]),
    .s1_r       (r[1]),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_model #(
    .ADDR_BITS (sram_pkg::ADDR_BITS),
    .DATA_BITS (sram_pkg::DATA_BITS)
  ) u_sram (
    .addr (sram_addr),
    .data (sram_data),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // plays every trace line of one port in file order
  task automatic run_port(input int p);
    logic [111:0] e;
    logic [31:0] addr_b;
    logic [31:0] rnd;
    bit aw_ok;
    bit w_ok;
    int gap;
    for (int i = 0; i < num_ops; i++) begin
      e = trace[i];
      if (e[111:108] == p[3:0]) begin
        // halfword address to byte address
        addr_b = {e[102:72], 1'b0};
        if (e[107:104] != 4'h0) begin
          // random strobes leave the data alone since the chip has no byte lanes
          rnd = $urandom;
          aw[p]      <= '{addr: addr_b};
          w[p]       <= '{data: e[71:40], strb: rnd[3:0]};
          awvalid[p] <= 1'b1;
          wvalid[p]  <= 1'b1;
          aw_ok = 1'b0;
          w_ok  = 1'b0;
          while (!(aw_ok && w_ok)) begin
            @(posedge clk);
            if (!aw_ok && awready[p]) begin
              aw_ok = 1'b1;
              awvalid[p] <= 1'b0;
            end
            if (!w_ok && wready[p]) begin
              w_ok = 1'b1;
              wvalid[p] <= 1'b0;
            end
          end
          while (!bvalid[p]) begin
            @(posedge clk);
          end
          // response must hold while bready stays low
          repeat (e[7:0]) begin
            @(posedge clk);
            check("bvalid", 32'd1, 32'(bvalid[p]));
          end
          bready[p] <= 1'b1;
          @(posedge clk);
          check("bvalid", 32'd1, 32'(bvalid[p]));
          check("bresp", 32'd0, 32'(b[p].resp));
          bready[p] <= 1'b0;
          @(posedge clk);
          check("bvalid_after", 32'd0, 32'(bvalid[p]));
        end else begin
          ar[p]      <= '{addr: addr_b};
          arvalid[p] <= 1'b1;
          @(posedge clk);
          while (!arready[p]) begin
            @(posedge clk);
          end
          arvalid[p] <= 1'b0;
          while (!rvalid[p]) begin
            @(posedge clk);
          end
          // data and valid stay put during the stall
          repeat (e[7:0]) begin
            @(posedge clk);
            check("rvalid", 32'd1, 32'(rvalid[p]));
            check("rdata_stable", e[39:8], r[p].data);
          end
          rready[p] <= 1'b1;
          @(posedge clk);
          check("rvalid", 32'd1, 32'(rvalid[p]));
          check("rdata", e[39:8], r[p].data);
          check("rresp", 32'd0, 32'(r[p].resp));
          rready[p] <= 1'b0;
          @(posedge clk);
          check("rvalid_after", 32'd0, 32'(rvalid[p]));
        end
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge clk);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'ha13f));
    errors = 0;
    loaded = 1'b0;
    reset  = 1'b1;
    for (int p = 0; p < 2; p++) begin
      awvalid[p] = 1'b0;
      aw[p]      = '{addr: 32'd0};
      wvalid[p]  = 1'b0;
      w[p]       = '{data: 32'd0, strb: 4'd0};
      bready[p]  = 1'b0;
      arvalid[p] = 1'b0;
      ar[p]      = '{addr: 32'd0};
      rready[p]  = 1'b0;
    end
    // sentinel marks the end of the loaded lines
    for (int i = 0; i < MAX_OPS; i++) begin
      trace[i] = '1;
    end
    $readmemh("tb/sram_trace.txt", trace);
    num_ops = 0;
    while (num_ops < MAX_OPS && trace[num_ops][111:108] != 4'hf) begin
      num_ops++;
    end
    loaded = 1'b1;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    reset <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    // idle state right after reset
    for (int p = 0; p < 2; p++) begin
      check("bvalid_reset", 32'd0, 32'(bvalid[p]));
      check("rvalid_reset", 32'd0, 32'(rvalid[p]));
    end
    check("sram_we_n_reset", 32'd1, 32'(sram_we_n));
    check("sram_oe_n_reset", 32'd1, 32'(sram_oe_n));
    check("sram_data_hiz", 32'd1, 32'(sram_data === 16'hzzzz));
    fork
      run_port(0);
      run_port(1);
    join
    $display("trace lines %0d, errors %0d", num_ops, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // run length bound of 40 cycles per trace line plus reset
  initial begin
    wait (loaded);
    #((num_ops * 40 + RESET_CYCLES) * 8);
    $display("timeout: trace did not finish within %0d cycles",
             num_ops * 40 + RESET_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
